/* compile.f */
+incdir+common
common/rv_isa_pkg.sv
common/mem_bus_pkg.sv
common/mem_port_if.sv
hw/core/decode_unit.sv
hw/core/alu.sv
hw/core/reg_file.sv
hw/core/core_pipeline.sv
hw/mem_arbiter.sv
hw/rv_subsystem_top.sv
bench/tb_clock_gen.sv
bench/tb_rv_subsystem.sv

/* Bender.yml */
package:
  name: rv_subsystem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rv_isa_pkg.sv
      - common/mem_bus_pkg.sv
      - common/mem_port_if.sv
      - hw/core/decode_unit.sv
      - hw/core/alu.sv
      - hw/core/reg_file.sv
      - hw/core/core_pipeline.sv
      - hw/mem_arbiter.sv
      - hw/rv_subsystem_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_rv_subsystem.sv

/* bench/tb_rv_subsystem.sv */
`include "core_params.svh"

`default_nettype none

module tb_rv_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;
    import mem_bus_pkg::*;

    localparam int MEM_WORDS      = 1 << (`CORE_ADDR_WIDTH - 2);
    localparam int PROG_WORDS     = 128;
    localparam int DATA_BASE      = 12'h400;
    localparam int RUN_LIMIT      = PROG_WORDS * 8;
    localparam int NUM_TESTS      = 4;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (RUN_LIMIT + 40) + 100;

    logic                        CLK;
    logic                        RESET_N;
    wire                         gen_rst_n;
    logic                        test_rst_n;
    logic [`CORE_ADDR_WIDTH-3:0] mem_addr;
    logic [`CORE_XLEN-1:0]       mem_wdata;
    logic                        mem_we;
    logic                        mem_re;
    logic [`CORE_XLEN-1:0]       mem_rdata;

    logic [`CORE_XLEN-1:0] mem [MEM_WORDS];
    logic [`CORE_XLEN-1:0] prog [PROG_WORDS];
    int                    prog_len;
    int                    loop_word;
    int                    target_q [$];
    mem_req_t              exp_q [$];
    mem_req_t              seen_q [$];
    int                    exp_addr_q [$];
    logic [`CORE_XLEN-1:0] exp_val_q [$];

    bit  program_done;
    bit  fetch_started;
    int  last_fetch;
    int  value_errors;
    int  other_errors;
    integer seed;

    logic [2:0] r_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic       r_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    logic [2:0] i_f3 [9] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic       i_alt [9] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) u_clock (
        .CLK     (CLK),
        .RESET_N (gen_rst_n)
    );

    assign RESET_N = gen_rst_n & test_rst_n;

    rv_subsystem_top dut (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_rdata (mem_rdata)
    );

    initial begin
        test_rst_n = 1'b1;
        mem_rdata  = '0;
    end

    // instruction encoders
    function automatic logic [31:0] r_type(input logic alt, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    // reference results by the RV32I rules
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic [31:0] fill_word(input int addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    endfunction

    function automatic bit target_hit(input int addr);
        foreach (target_q[i]) begin
            if (target_q[i] == addr) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic emit(input logic [31:0] word);
        if (prog_len >= PROG_WORDS) begin
            other_errors++;
            $display("program does not fit in %0d words", PROG_WORDS);
        end else begin
            prog[prog_len] = word;
            prog_len++;
        end
    endtask

    task automatic nops(input int n);
        repeat (n) emit(i_type(12'h0, 5'd0, 3'd0, 5'd0, OP_IMM));
    endtask

    // lui plus addi, upper part rounded for the signed low part
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = (value + 32'h800) >> 12;
        emit(u_type(upper[19:0], rd, LUI));
        // no forwarding, addi reads rd only after lui wrote it
        nops(3);
        emit(i_type(value[11:0], rd, 3'd0, rd, OP_IMM));
    endtask

    task automatic expect_word(input int off, input logic [31:0] value);
        exp_addr_q.push_back((DATA_BASE + off) >> 2);
        exp_val_q.push_back(value);
    endtask

    // x10 holds the data base in every program
    task automatic store_expect(input logic [4:0] rs2, input int off, input logic [31:0] value);
        mem_req_t req;
        emit(s_type(off[11:0], rs2, 5'd10));
        req = '{addr: (DATA_BASE + off) >> 2, wdata: value, we: 1'b1, re: 1'b0};
        exp_q.push_back(req);
        expect_word(off, value);
    endtask

    task automatic load_expect(input logic [4:0] rd, input int off);
        mem_req_t req;
        emit(i_type(off[11:0], 5'd10, 3'b010, rd, LOAD));
        req = '{addr: (DATA_BASE + off) >> 2, wdata: '0, we: 1'b0, re: 1'b1};
        exp_q.push_back(req);
    endtask

    task automatic begin_program();
        prog_len = 0;
        target_q.delete();
        exp_q.delete();
        exp_addr_q.delete();
        exp_val_q.delete();
        emit(i_type(DATA_BASE[11:0], 5'd0, 3'd0, 5'd10, OP_IMM));
    endtask

    task automatic end_program();
        nops(5);
        loop_word = prog_len;
        target_q.push_back(prog_len);
        emit(j_type(21'd0, 5'd0));
    endtask

    task automatic check_word(input string name, input logic [`CORE_XLEN-1:0] got,
                              input logic [`CORE_XLEN-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
        if (got.addr !== exp.addr || got.we !== exp.we || got.re !== exp.re ||
            (exp.we && got.wdata !== exp.wdata)) begin
            value_errors++;
            $display("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_fetch(input int addr);
        if (!fetch_started && addr != (`CORE_RESET_PC >> 2)) begin
            other_errors++;
            $display("first fetch at %0d ns is not the reset address", $time);
        end else if (fetch_started && addr != last_fetch + 1 && !target_hit(addr)) begin
            other_errors++;
            $display("fetch at %0d ns jumped from word %0d to word %0d", $time, last_fetch, addr);
        end
        fetch_started = 1'b1;
        last_fetch    = addr;
        if (addr == loop_word) begin
            program_done = 1'b1;
        end
    endtask

    // memory model, data region above the program area
    always @(posedge CLK) begin : memory_model
        logic [`CORE_XLEN-1:0] rd_word;
        mem_req_t              seen;
        rd_word = '0;
        if (RESET_N && (mem_we || mem_re)) begin
            if (mem_we && mem_re) begin
                other_errors++;
                $display("read and write strobes both high at %0d ns", $time);
            end
            seen = '{addr: mem_addr, wdata: mem_wdata, we: mem_we, re: mem_re};
            if (mem_addr >= (DATA_BASE >> 2)) begin
                seen_q.push_back(seen);
            end else if (mem_we) begin
                other_errors++;
                $display("store into the program area at %0d ns", $time);
            end else begin
                check_fetch(mem_addr);
            end
            if (mem_we) begin
                mem[mem_addr] = mem_wdata;
            end else begin
                rd_word = mem[mem_addr];
            end
        end
        #2;
        mem_rdata = rd_word;
    end

    task automatic check_results(input string name);
        int n;
        if (seen_q.size() != exp_q.size()) begin
            other_errors++;
            $display("%s: %0d data accesses seen, %0d expected", name, seen_q.size(),
                     exp_q.size());
        end
        n = (seen_q.size() < exp_q.size()) ? seen_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            check_req($sformatf("%s access %0d", name, i), seen_q[i], exp_q[i]);
        end
        foreach (exp_addr_q[i]) begin
            check_word($sformatf("%s mem[%0d]", name, exp_addr_q[i]), mem[exp_addr_q[i]],
                       exp_val_q[i]);
        end
    endtask

    task automatic run_program(input string name);
        int cycles;
        @(posedge CLK);
        #2;
        test_rst_n = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        for (int i = 0; i < prog_len; i++) begin
            mem[i] = prog[i];
        end
        seen_q.delete();
        fetch_started = 1'b0;
        program_done  = 1'b0;
        repeat (3) @(posedge CLK);
        #2 test_rst_n = 1'b1;
        cycles = 0;
        while (!program_done && cycles < RUN_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        if (!program_done) begin
            other_errors++;
            $display("%s: program never reached its end loop", name);
        end
        // let the last stores drain
        repeat (12) @(posedge CLK);
        #2;
        check_results(name);
    endtask

    task automatic arith_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_val;
        logic [11:0] imm;
        a = $random(seed);
        b = $random(seed);
        begin_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        nops(3);
        for (int k = 0; k < 10; k++) begin
            emit(r_type(r_alt[k], 5'd2, 5'd1, r_f3[k], 5'd3));
            nops(3);
            store_expect(5'd3, 4 * k, alu_ref(r_f3[k], r_alt[k], a, b));
        end
        for (int k = 0; k < 9; k++) begin
            if (i_f3[k] == 3'd1 || i_f3[k] == 3'd5) begin
                imm = {1'b0, i_alt[k], 5'b0, b[4:0]};
            end else begin
                imm = $random(seed);
            end
            imm_val = {{20{imm[11]}}, imm};
            emit(i_type(imm, 5'd1, i_f3[k], 5'd3, OP_IMM));
            nops(3);
            store_expect(5'd3, 40 + 4 * k, alu_ref(i_f3[k], i_alt[k], a, imm_val));
        end
        end_program();
        run_program("arith");
    endtask

    task automatic load_store_test();
        logic [31:0] a;
        logic [31:0] b;
        a = $random(seed);
        b = $random(seed);
        begin_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        nops(3);
        store_expect(5'd1, 0, a);
        store_expect(5'd2, 8, b);
        load_expect(5'd4, 0);
        load_expect(5'd5, 8);
        nops(3);
        store_expect(5'd4, 12'h40, a);
        store_expect(5'd5, 12'h48, b);
        end_program();
        run_program("load_store");
    endtask

    // a taken branch skips the first store
    task automatic branch_guard(input logic [2:0] f3, input logic [4:0] rs2, input bit taken,
                                input int off, input logic [31:0] value);
        target_q.push_back(prog_len + 2);
        emit(b_type(13'd8, rs2, 5'd1, f3));
        if (taken) begin
            emit(s_type(off[11:0], 5'd1, 5'd10));
            expect_word(off, fill_word((DATA_BASE + off) >> 2));
        end else begin
            store_expect(5'd1, off, value);
        end
        store_expect(5'd1, off + 4, value);
    endtask

    task automatic branch_test();
        logic [31:0] a;
        logic [31:0] b;
        a = $random(seed);
        b = a ^ ($random(seed) | 32'h1);
        begin_program();
        load_const(5'd1, a);
        load_const(5'd2, a);
        load_const(5'd3, b);
        nops(3);
        branch_guard(3'b000, 5'd2, 1'b1, 12'h00, a);
        branch_guard(3'b001, 5'd2, 1'b0, 12'h08, a);
        branch_guard(3'b000, 5'd3, 1'b0, 12'h10, a);
        branch_guard(3'b001, 5'd3, 1'b1, 12'h18, a);
        end_program();
        run_program("branch");
    endtask

    task automatic upper_jump_test();
        logic [19:0] u1;
        logic [19:0] u2;
        int          auipc_pc;
        int          jal_pc;
        u1 = $random(seed);
        u2 = $random(seed);
        begin_program();
        emit(u_type(u1, 5'd4, LUI));
        auipc_pc = prog_len * 4;
        emit(u_type(u2, 5'd5, AUIPC));
        jal_pc = prog_len * 4;
        target_q.push_back(prog_len + 3);
        emit(j_type(21'd12, 5'd6));
        emit(s_type(12'h30, 5'd0, 5'd10));
        emit(s_type(12'h34, 5'd0, 5'd10));
        nops(3);
        store_expect(5'd4, 0, {u1, 12'b0});
        store_expect(5'd5, 4, auipc_pc + {u2, 12'b0});
        store_expect(5'd6, 8, jal_pc + 4);
        expect_word(12'h30, fill_word((DATA_BASE + 12'h30) >> 2));
        end_program();
        run_program("upper_jump");
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 40);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed         = 32'h909a_2e22;
        value_errors = 0;
        other_errors = 0;
        loop_word    = -1;
        wait (gen_rst_n === 1'b1);
        arith_test();
        load_store_test();
        branch_test();
        upper_jump_test();
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic CLK,
    output logic RESET_N
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // release a little after the edge
    initial begin
        RESET_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2 RESET_N = 1'b1;
    end

endmodule

`default_nettype wire

/* hw/rv_subsystem_top.sv */
`include "core_params.svh"

`default_nettype none

module rv_subsystem_top (
    input  wire logic                   CLK,
    input  wire logic                   RESET_N,
    output logic [`CORE_ADDR_WIDTH-3:0] mem_addr,
    output logic [`CORE_XLEN-1:0]       mem_wdata,
    output logic                        mem_we,
    output logic                        mem_re,
    input  wire logic [`CORE_XLEN-1:0]  mem_rdata
);

    mem_port_if fetch_port ();
    mem_port_if data_port ();

    core_pipeline u_pipeline (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .fetch   (fetch_port),
        .data    (data_port)
    );

    // single shared port toward memory
    mem_arbiter u_arbiter (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .fetch     (fetch_port),
        .data      (data_port),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
`include "core_params.svh"

`default_nettype none

module mem_arbiter (
    input  wire logic                        CLK,
    input  wire logic                        RESET_N,
    mem_port_if.arbiter                      fetch,
    mem_port_if.arbiter                      data,
    output logic [`CORE_ADDR_WIDTH-3:0]      mem_addr,
    output logic [`CORE_XLEN-1:0]            mem_wdata,
    output logic                             mem_we,
    output logic                             mem_re,
    input  wire logic [`CORE_XLEN-1:0]       mem_rdata
);
    import mem_bus_pkg::*;

    mem_req_t   sel_req;
    requester_t owner;

    // data wins, fetch waits a cycle
    assign data.gnt  = data.req;
    assign fetch.gnt = fetch.req && !data.req;

    always_comb begin
        if (data.req) begin
            sel_req = '{addr: data.addr, wdata: data.wdata, we: data.we, re: !data.we};
        end else begin
            sel_req = '{addr: fetch.addr, wdata: fetch.wdata,
                        we: fetch.req && fetch.we, re: fetch.req && !fetch.we};
        end
    end

    assign mem_addr  = sel_req.addr;
    assign mem_wdata = sel_req.wdata;
    assign mem_we    = sel_req.we;
    assign mem_re    = sel_req.re;

    // who gets next cycle's read data
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            owner <= FETCH;
        end else begin
            owner <= data.req ? DATA : FETCH;
        end
    end

    assign fetch.rdata = (owner == FETCH) ? mem_rdata : '0;
    assign data.rdata  = (owner == DATA) ? mem_rdata : '0;

endmodule

`default_nettype wire

/* hw/core/core_pipeline.sv */
`include "core_params.svh"

`default_nettype none

module core_pipeline (
    input wire logic      CLK,
    input wire logic      RESET_N,
    mem_port_if.requester fetch,
    mem_port_if.requester data
);
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;

    localparam int REG_AW = $clog2(`CORE_REG_COUNT);

    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] fetch_pc;
    logic                  fetch_en;
    logic                  fetch_live;
    logic                  redirect;
    requester_t            mem_user;

    logic                  if_id_valid;
    logic [`CORE_XLEN-1:0] if_id_instr;
    logic [`CORE_XLEN-1:0] if_id_pc;

    ctrl_t                 id_ctrl;
    logic [`CORE_XLEN-1:0] id_imm;
    logic [`CORE_XLEN-1:0] id_rs1_data;
    logic [`CORE_XLEN-1:0] id_rs2_data;

    ctrl_t                 id_ex_ctrl;
    logic                  id_ex_bne;
    logic [`CORE_XLEN-1:0] id_ex_pc;
    logic [`CORE_XLEN-1:0] id_ex_imm;
    logic [`CORE_XLEN-1:0] id_ex_rs1_data;
    logic [`CORE_XLEN-1:0] id_ex_rs2_data;
    logic [REG_AW-1:0]     id_ex_rd;

    logic [`CORE_XLEN-1:0] alu_a;
    logic [`CORE_XLEN-1:0] alu_b;
    logic [`CORE_XLEN-1:0] alu_result;
    logic                  alu_zero;

    ctrl_t                 ex_mem_ctrl;
    logic                  ex_mem_bne;
    logic                  ex_mem_zero;
    logic [`CORE_XLEN-1:0] ex_mem_pc;
    logic [`CORE_XLEN-1:0] ex_mem_result;
    logic [`CORE_XLEN-1:0] ex_mem_store;
    logic [`CORE_XLEN-1:0] ex_mem_target;
    logic [REG_AW-1:0]     ex_mem_rd;

    ctrl_t                 mem_wb_ctrl;
    logic [`CORE_XLEN-1:0] mem_wb_pc;
    logic [`CORE_XLEN-1:0] mem_wb_result;
    logic [REG_AW-1:0]     mem_wb_rd;
    logic [`CORE_XLEN-1:0] wb_data;

    // fetch side, arbiter refusal holds the pc
    assign fetch.req   = fetch_en;
    assign fetch.we    = 1'b0;
    assign fetch.addr  = pc[`CORE_ADDR_WIDTH-1:2];
    assign fetch.wdata = '0;

    // loads and stores own the port during MEM
    assign mem_user   = (ex_mem_ctrl.mem_read || ex_mem_ctrl.mem_write) ? DATA : FETCH;
    assign data.req   = (mem_user == DATA);
    assign data.we    = ex_mem_ctrl.mem_write;
    assign data.addr  = ex_mem_result[`CORE_ADDR_WIDTH-1:2];
    assign data.wdata = ex_mem_store;

    // taken branch or jal sitting in MEM
    assign redirect = ex_mem_ctrl.jump || (ex_mem_ctrl.branch && (ex_mem_zero ^ ex_mem_bne));

    decode_unit u_decode (
        .instr (if_id_instr),
        .ctrl  (id_ctrl),
        .imm   (id_imm)
    );

    reg_file u_regs (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .rs1      (if_id_instr[19:15]),
        .rs2      (if_id_instr[24:20]),
        .rd       (mem_wb_rd),
        .rd_data  (wb_data),
        .we       (mem_wb_ctrl.reg_write),
        .rs1_data (id_rs1_data),
        .rs2_data (id_rs2_data)
    );

    // operand select: zero for lui, pc for auipc
    assign alu_a = id_ex_ctrl.a_src_zero ? '0 :
                   id_ex_ctrl.a_src_pc   ? id_ex_pc : id_ex_rs1_data;
    assign alu_b = id_ex_ctrl.alu_src_imm ? id_ex_imm : id_ex_rs2_data;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (id_ex_ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    always_comb begin
        case (mem_wb_ctrl.wb_sel)
            WB_MEM:  wb_data = data.rdata;
            WB_PC4:  wb_data = mem_wb_pc + `CORE_XLEN'(4);
            default: wb_data = mem_wb_result;
        endcase
    end

    // control state, redirect squashes the three younger slots
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc          <= `CORE_RESET_PC;
            fetch_en    <= 1'b0;
            fetch_live  <= 1'b0;
            if_id_valid <= 1'b0;
            id_ex_ctrl  <= '0;
            ex_mem_ctrl <= '0;
            mem_wb_ctrl <= '0;
        end else begin
            fetch_en    <= 1'b1;
            fetch_live  <= fetch.gnt && !redirect;
            if_id_valid <= fetch_live && !redirect;
            id_ex_ctrl  <= (redirect || !if_id_valid) ? '0 : id_ctrl;
            ex_mem_ctrl <= redirect ? '0 : id_ex_ctrl;
            mem_wb_ctrl <= ex_mem_ctrl;
            if (redirect) begin
                pc <= ex_mem_target;
            end else if (fetch.gnt) begin
                pc <= pc + `CORE_XLEN'(4);
            end
        end
    end

    // payload, qualified by the control above
    always_ff @(posedge CLK) begin
        fetch_pc       <= pc;
        if_id_instr    <= fetch.rdata;
        if_id_pc       <= fetch_pc;
        id_ex_bne      <= if_id_instr[12];
        id_ex_pc       <= if_id_pc;
        id_ex_imm      <= id_imm;
        id_ex_rs1_data <= id_rs1_data;
        id_ex_rs2_data <= id_rs2_data;
        id_ex_rd       <= if_id_instr[11:7];
        ex_mem_bne     <= id_ex_bne;
        ex_mem_zero    <= alu_zero;
        ex_mem_pc      <= id_ex_pc;
        ex_mem_result  <= alu_result;
        ex_mem_store   <= id_ex_rs2_data;
        ex_mem_target  <= id_ex_pc + id_ex_imm;
        ex_mem_rd      <= id_ex_rd;
        mem_wb_pc      <= ex_mem_pc;
        mem_wb_result  <= ex_mem_result;
        mem_wb_rd      <= ex_mem_rd;
    end

endmodule

`default_nettype wire

/* hw/core/reg_file.sv */
`include "core_params.svh"

`default_nettype none

module reg_file (
    input  wire logic                               CLK,
    input  wire logic                               RESET_N,
    input  wire logic [$clog2(`CORE_REG_COUNT)-1:0] rs1,
    input  wire logic [$clog2(`CORE_REG_COUNT)-1:0] rs2,
    input  wire logic [$clog2(`CORE_REG_COUNT)-1:0] rd,
    input  wire logic [`CORE_XLEN-1:0]              rd_data,
    input  wire logic                               we,
    output logic [`CORE_XLEN-1:0]                   rs1_data,
    output logic [`CORE_XLEN-1:0]                   rs2_data
);

    logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // write-through so WB and ID can share a cycle
    assign rs1_data = (rs1 == '0) ? '0 : (we && rd == rs1) ? rd_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (we && rd == rs2) ? rd_data : regs[rs2];

endmodule

`default_nettype wire

/* hw/core/alu.sv */
`include "core_params.svh"

`default_nettype none

module alu (
    input  wire logic [`CORE_XLEN-1:0] a,
    input  wire logic [`CORE_XLEN-1:0] b,
    input  rv_isa_pkg::alu_op_t        op,
    output logic [`CORE_XLEN-1:0]      result,
    output logic                       zero
);
    import rv_isa_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = `CORE_XLEN'($signed(a) < $signed(b));
            ALU_SLTU: result = `CORE_XLEN'(a < b);
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            default:  result = a & b;
        endcase
    end

    // equal operands when op is SUB
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* hw/core/decode_unit.sv */
`include "core_params.svh"

`default_nettype none

module decode_unit (
    input  wire logic [`CORE_XLEN-1:0] instr,
    output rv_isa_pkg::ctrl_t          ctrl,
    output logic [`CORE_XLEN-1:0]      imm
);
    import rv_isa_pkg::*;

    opcode_t opcode;
    alu_op_t arith_op;
    logic [2:0] funct3;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];

    // bit 30 picks SUB only for register form, SRA for both forms
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OP && instr[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = instr[30] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op;
            end
            OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = arith_op;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.wb_sel      = WB_MEM;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            BRANCH: begin
                // compare by subtraction, zero flag decides
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.a_src_zero  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {instr[31:12], 12'b0};
            end
            AUIPC: begin
                ctrl.reg_write   = 1'b1;
                ctrl.a_src_pc    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {instr[31:12], 12'b0};
            end
            JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                // unknown opcode stays a bubble
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* common/mem_port_if.sv */
`include "core_params.svh"

`default_nettype none

interface mem_port_if;

    logic                        req;
    logic                        we;
    logic [`CORE_ADDR_WIDTH-3:0] addr;
    logic [`CORE_XLEN-1:0]       wdata;
    logic                        gnt;
    // valid the cycle after a granted read
    logic [`CORE_XLEN-1:0]       rdata;

    modport requester (output req, we, addr, wdata, input gnt, rdata);

    modport arbiter (input req, we, addr, wdata, output gnt, rdata);

endinterface

`default_nettype wire

/* common/mem_bus_pkg.sv */
`include "core_params.svh"

`default_nettype none

package mem_bus_pkg;

    typedef enum logic {
        FETCH,
        DATA
    } requester_t;

    // one access on the shared port, word addressed
    typedef struct packed {
        logic [`CORE_ADDR_WIDTH-3:0] addr;
        logic [`CORE_XLEN-1:0]       wdata;
        logic                        we;
        logic                        re;
    } mem_req_t;

endpackage

`default_nettype wire

/* common/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_t;

    // all zero is a bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        logic    alu_src_imm;
        logic    a_src_pc;
        logic    a_src_zero;
        wb_sel_t wb_sel;
        alu_op_t alu_op;
    } ctrl_t;

endpackage

`default_nettype wire

/* common/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path width
`define CORE_XLEN 32

// byte address width of the shared memory
`define CORE_ADDR_WIDTH 12

`define CORE_RESET_PC 0
`define CORE_REG_COUNT 32

`endif
